/* source/cdrom_pkg.sv */
package cdrom_pkg;

	// ----------------------------------------
	// Audio path sizes
	// ----------------------------------------
	localparam int N_CHAN = 2;                 // Stereo
	localparam int CH_L = 0;
	localparam int CH_R = 1;
	localparam int PCM_W = 16;                 // Signed PCM sample width
	localparam int FIFO_DEPTH = 16;            // Per channel, also initial credits
	localparam int CREDIT_W = $clog2(FIFO_DEPTH + 1);
	localparam int SAMPLE_PERIOD = 768;        // Clocks per output sample
	localparam int VOL_UNITY_SHIFT = 7;        // 0x80 is unity gain

	// ----------------------------------------
	// CPU register addresses
	// ----------------------------------------
	localparam logic [1:0] REG_STATUS = 2'd0;  // Index write, status read
	localparam logic [1:0] REG_DATA1 = 2'd1;
	localparam logic [1:0] REG_DATA2 = 2'd2;
	localparam logic [1:0] REG_DATA3 = 2'd3;

	// Stereo sample pair
	// Right sits in the upper word so that lane CH_L is bits [PCM_W-1:0]
	typedef struct packed {
		logic signed [PCM_W-1:0] r;
		logic signed [PCM_W-1:0] l;
	} pcm_pair_t;

	// 2x2 volume matrix, unsigned, 0x80 = 100%
	typedef struct packed {
		logic [7:0] ll; // Left in to left out
		logic [7:0] rl; // Right in to left out
		logic [7:0] lr; // Left in to right out
		logic [7:0] rr; // Right in to right out
	} vol_set_t;

endpackage

/* source/cdrom_pcm_fifo.sv */
module cdrom_pcm_fifo (
	input  logic                                i_clk,
	input  logic                                i_nrst,
	input  logic                                i_push,
	input  logic signed [cdrom_pkg::PCM_W-1:0]  i_data,
	input  logic                                i_pop,
	output logic signed [cdrom_pkg::PCM_W-1:0]  o_data,
	output logic                                o_not_empty,
	output logic                                o_credit
);

	logic signed [cdrom_pkg::PCM_W-1:0] mem [cdrom_pkg::FIFO_DEPTH];

	// Depth is a power of two, pointers wrap by themselves
	logic [$clog2(cdrom_pkg::FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(cdrom_pkg::FIFO_DEPTH)-1:0] rd_ptr;
	logic [cdrom_pkg::CREDIT_W-1:0] count;

	// Storage
	always_ff @(posedge i_clk) begin
		if (i_push)
			mem[wr_ptr] <= i_data;
	end

	// ----------------------------------------
	// Pointers, level and credit return
	// ----------------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_nrst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			o_credit <= 1'b0;
		end else begin
			if (i_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({i_push, i_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ; // Push and pop together keep the level
			endcase
			o_credit <= i_pop; // One credit per sample drained
		end
	end

	assign o_data = mem[rd_ptr]; // Head always visible
	assign o_not_empty = (count != '0);

	// Credit flow on the feeder side must keep this from firing
	a_no_overrun: assert property (@(posedge i_clk) disable iff (!i_nrst)
		!(i_push && !i_pop && count == cdrom_pkg::FIFO_DEPTH) && !(i_pop && count == '0))
		else $error("FIFO overrun or underrun, count %0d", count);

endmodule

/* source/cdrom_pcm_feeder.sv */
module cdrom_pcm_feeder (
	input  logic                              i_clk,
	input  logic                              i_nrst,
	input  logic                              i_pcm_valid,
	input  cdrom_pkg::pcm_pair_t              i_pcm,
	input  logic [cdrom_pkg::N_CHAN-1:0]      i_credit,
	output logic                              o_pcm_ready,
	output logic [cdrom_pkg::N_CHAN-1:0]      o_push,
	output cdrom_pkg::pcm_pair_t              o_push_data
);

	logic [cdrom_pkg::N_CHAN-1:0][cdrom_pkg::CREDIT_W-1:0] credit_cnt;
	logic [cdrom_pkg::N_CHAN-1:0][cdrom_pkg::CREDIT_W-1:0] credit_nxt;
	logic [cdrom_pkg::N_CHAN-1:0] credit_ok;
	logic take;

	assign take = i_pcm_valid & o_pcm_ready;
	assign o_push = {cdrom_pkg::N_CHAN{take}}; // Both lanes move together
	assign o_push_data = i_pcm;

	// Spend on push, regain on credit pulse
	always_comb begin
		for (int ch = 0; ch < cdrom_pkg::N_CHAN; ch++) begin
			case ({o_push[ch], i_credit[ch]})
				2'b10: credit_nxt[ch] = credit_cnt[ch] - 1'b1;
				2'b01: credit_nxt[ch] = credit_cnt[ch] + 1'b1;
				default: credit_nxt[ch] = credit_cnt[ch]; // Idle or both cancel
			endcase
			credit_ok[ch] = (credit_nxt[ch] != '0);
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_nrst) begin
			for (int ch = 0; ch < cdrom_pkg::N_CHAN; ch++)
				credit_cnt[ch] <= cdrom_pkg::CREDIT_W'(cdrom_pkg::FIFO_DEPTH);
			o_pcm_ready <= 1'b1; // Full credit after reset
		end else begin
			credit_cnt <= credit_nxt;
			o_pcm_ready <= &credit_ok; // Tracks the counters, never i_pcm_valid
		end
	end

	// ----------------------------------------
	// Credit checks
	// ----------------------------------------
	for (genvar ch = 0; ch < cdrom_pkg::N_CHAN; ch++) begin : g_chk
		a_no_push_dry: assert property (@(posedge i_clk) disable iff (!i_nrst)
			o_push[ch] |-> (credit_cnt[ch] != '0))
			else $error("Push on lane %0d with zero credit", ch);
		a_credit_max: assert property (@(posedge i_clk) disable iff (!i_nrst)
			credit_cnt[ch] <= cdrom_pkg::FIFO_DEPTH)
			else $error("Credit overflow on lane %0d: %0d", ch, credit_cnt[ch]);
	end

endmodule

/* source/cdrom_host_regs.sv */
module cdrom_host_regs (
	input  logic                 i_clk,
	input  logic                 i_nrst,
	input  logic                 i_cs,
	input  logic                 i_write,
	input  logic [1:0]           i_adr,
	input  logic [7:0]           i_wdata,
	input  logic                 i_fifo_any_data,
	input  logic                 i_fifo_all_empty,
	input  logic                 i_pcm_ready,
	output logic [7:0]           o_rdata,
	output cdrom_pkg::vol_set_t  o_vol_work
);

	logic [2:0] index_q;                   // Bank select
	cdrom_pkg::vol_set_t vol_stage;        // Written by CPU, not yet in use
	cdrom_pkg::vol_set_t vol_work;         // Feeds the mixer
	logic [4:0] int_en;                    // Interrupt enable
	logic [2:0] int_spare;                 // Stored only, no function
	logic wr_en;
	logic apply_wr;

	assign wr_en = i_cs & i_write;

	// Index 3 on address 3, bit 5 latches the staged set
	assign apply_wr = wr_en & (i_adr == cdrom_pkg::REG_DATA3) & (index_q == 3'd3) & i_wdata[5];

	// ----------------------------------------
	// Register writes
	// ----------------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_nrst) begin
			index_q <= 3'd0;
			vol_stage <= '0;
			vol_work <= '0;
			int_en <= 5'd0;
			int_spare <= 3'd0;
		end else begin
			if (wr_en) begin
				case (i_adr)
					cdrom_pkg::REG_STATUS: index_q <= i_wdata[2:0];
					cdrom_pkg::REG_DATA1: begin
						if (index_q == 3'd3)
							vol_stage.rr <= i_wdata;
					end
					cdrom_pkg::REG_DATA2: begin
						case (index_q)
							3'd1: begin
								int_en <= i_wdata[4:0];
								int_spare <= i_wdata[7:5];
							end
							3'd2: vol_stage.ll <= i_wdata;
							3'd3: vol_stage.rl <= i_wdata;
							default: ; // Parameter FIFO lives elsewhere
						endcase
					end
					cdrom_pkg::REG_DATA3: begin
						if (index_q == 3'd2)
							vol_stage.lr <= i_wdata;
					end
					default: ;
				endcase
			end
			if (apply_wr)
				vol_work <= vol_stage; // Whole matrix in one edge
		end
	end

	assign o_vol_work = vol_work;

	// ----------------------------------------
	// Read mux
	// ----------------------------------------
	always_comb begin
		case (i_adr)
			cdrom_pkg::REG_STATUS: begin
				o_rdata = {
					2'b00,
					i_fifo_any_data,    // Bit 5
					i_pcm_ready,        // Bit 4, room for a sample
					i_fifo_all_empty,   // Bit 3
					index_q
				};
			end
			cdrom_pkg::REG_DATA3: begin
				// Even banks show the enable byte, odd banks the flags (not kept)
				if (index_q[0])
					o_rdata = 8'h00;
				else
					o_rdata = {int_spare, int_en};
			end
			default: o_rdata = 8'h00; // Response and data FIFOs not present
		endcase
	end

	// Working volumes move only right after an apply strobe
	a_vol_apply_only: assert property (@(posedge i_clk) disable iff (!i_nrst)
		(vol_work != $past(vol_work)) |-> $past(apply_wr))
		else $error("o_vol_work changed without apply write");

endmodule

/* source/cdrom_audio_mixer.sv */
module cdrom_audio_mixer (
	input  logic                              i_clk,
	input  logic                              i_nrst,
	input  cdrom_pkg::pcm_pair_t              i_head,
	input  logic [cdrom_pkg::N_CHAN-1:0]      i_not_empty,
	input  cdrom_pkg::vol_set_t               i_vol,
	output logic [cdrom_pkg::N_CHAN-1:0]      o_pop,
	output cdrom_pkg::pcm_pair_t              o_audio,
	output logic                              o_audio_strobe
);

	logic [$clog2(cdrom_pkg::SAMPLE_PERIOD)-1:0] div_cnt;
	logic tick;                                   // Terminal count
	logic signed [cdrom_pkg::PCM_W-1:0] smp_l;
	logic signed [cdrom_pkg::PCM_W-1:0] smp_r;
	logic signed [cdrom_pkg::PCM_W-1:0] mix_l;
	logic signed [cdrom_pkg::PCM_W-1:0] mix_r;

	// Two products, scale back from 0x80 unity, clip to 16 bits
	function automatic logic signed [cdrom_pkg::PCM_W-1:0] mix_sat(
		input logic signed [cdrom_pkg::PCM_W-1:0] a,
		input logic signed [cdrom_pkg::PCM_W-1:0] b,
		input logic [7:0]                         va,
		input logic [7:0]                         vb
	);
		logic signed [cdrom_pkg::PCM_W+9:0] acc;  // 16x9 bit products plus carry
		logic [10:0] top_bits;
		acc = (a * $signed({1'b0, va}) + b * $signed({1'b0, vb}))
			>>> cdrom_pkg::VOL_UNITY_SHIFT;
		top_bits = acc[cdrom_pkg::PCM_W+9:cdrom_pkg::PCM_W-1];
		if ((&top_bits) | (~|top_bits))
			return acc[cdrom_pkg::PCM_W-1:0];  // Fits as is
		// Overflow, pin to max or min by sign
		return {acc[cdrom_pkg::PCM_W+9], {(cdrom_pkg::PCM_W-1){~acc[cdrom_pkg::PCM_W+9]}}};
	endfunction

	// ----------------------------------------
	// Sample rate divider
	// ----------------------------------------
	assign tick = (div_cnt == cdrom_pkg::SAMPLE_PERIOD - 1);

	always_ff @(posedge i_clk) begin
		if (!i_nrst)
			div_cnt <= '0;
		else if (tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// Drain one sample per channel, only if present
	assign o_pop = {cdrom_pkg::N_CHAN{tick}} & i_not_empty;

	// Empty lane plays silence
	assign smp_l = i_not_empty[cdrom_pkg::CH_L] ? i_head.l : '0;
	assign smp_r = i_not_empty[cdrom_pkg::CH_R] ? i_head.r : '0;

	assign mix_l = mix_sat(smp_l, smp_r, i_vol.ll, i_vol.rl);
	assign mix_r = mix_sat(smp_l, smp_r, i_vol.lr, i_vol.rr);

	// ----------------------------------------
	// Output register
	// ----------------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_nrst) begin
			o_audio <= '0;
			o_audio_strobe <= 1'b0;
		end else begin
			o_audio_strobe <= tick;  // One cycle wide
			if (tick) begin
				o_audio.l <= mix_l;
				o_audio.r <= mix_r;
			end
		end
	end

endmodule

/* source/cdrom_audio_top.sv */
module cdrom_audio_top (
	input  logic                  i_clk,
	input  logic                  i_nrst,
	input  logic                  i_cs,
	input  logic                  i_write,
	input  logic [1:0]            i_adr,
	input  logic [7:0]            i_wdata,
	input  logic                  i_pcm_valid,
	input  cdrom_pkg::pcm_pair_t  i_pcm,
	output logic [7:0]            o_rdata,
	output logic                  o_pcm_ready,
	output cdrom_pkg::pcm_pair_t  o_audio,
	output logic                  o_audio_strobe
);

	cdrom_pkg::vol_set_t vol_work;
	cdrom_pkg::pcm_pair_t push_data;
	logic [cdrom_pkg::N_CHAN-1:0] push;
	logic [cdrom_pkg::N_CHAN-1:0] credit;
	logic [cdrom_pkg::N_CHAN-1:0] pop;
	logic [cdrom_pkg::N_CHAN-1:0] not_empty;

	// Lane views of the pair, index 0 is left
	wire [cdrom_pkg::N_CHAN-1:0][cdrom_pkg::PCM_W-1:0] push_lane = push_data;
	wire [cdrom_pkg::N_CHAN-1:0][cdrom_pkg::PCM_W-1:0] head_lane;
	wire cdrom_pkg::pcm_pair_t head = head_lane;

	cdrom_host_regs cdrom_host_regs_i (
		.i_clk            (i_clk),
		.i_nrst           (i_nrst),
		.i_cs             (i_cs),
		.i_write          (i_write),
		.i_adr            (i_adr),
		.i_wdata          (i_wdata),
		.i_fifo_any_data  (|not_empty),
		.i_fifo_all_empty (~|not_empty),
		.i_pcm_ready      (o_pcm_ready),
		.o_rdata          (o_rdata),
		.o_vol_work       (vol_work)
	);

	cdrom_pcm_feeder cdrom_pcm_feeder_i (
		.i_clk       (i_clk),
		.i_nrst      (i_nrst),
		.i_pcm_valid (i_pcm_valid),
		.i_pcm       (i_pcm),
		.i_credit    (credit),
		.o_pcm_ready (o_pcm_ready),
		.o_push      (push),
		.o_push_data (push_data)
	);

	// One sample FIFO per channel
	for (genvar ch = 0; ch < cdrom_pkg::N_CHAN; ch++) begin : g_chan
		cdrom_pcm_fifo cdrom_pcm_fifo_i (
			.i_clk       (i_clk),
			.i_nrst      (i_nrst),
			.i_push      (push[ch]),
			.i_data      (push_lane[ch]),
			.i_pop       (pop[ch]),
			.o_data      (head_lane[ch]),
			.o_not_empty (not_empty[ch]),
			.o_credit    (credit[ch])
		);
	end

	cdrom_audio_mixer cdrom_audio_mixer_i (
		.i_clk          (i_clk),
		.i_nrst         (i_nrst),
		.i_head         (head),
		.i_not_empty    (not_empty),
		.i_vol          (vol_work),
		.o_pop          (pop),
		.o_audio        (o_audio),
		.o_audio_strobe (o_audio_strobe)
	);

endmodule

/* tests/cdrom_audio_tb.sv */
module cdrom_audio_tb;

	localparam int HALF = 50;
	localparam int PERIOD = 2 * HALF;
	localparam int N_RAND = 4;                  // Random volume rounds of 3 samples
	// Strobes for reset, staging, unity, random, clip, back-pressure and underrun
	localparam int N_STROBES = 2 + 1 + 4 + N_RAND * 3 + 2 + (3 + cdrom_pkg::FIFO_DEPTH) + 2;
	localparam longint WATCHDOG = longint'(N_STROBES + 4) * cdrom_pkg::SAMPLE_PERIOD * PERIOD;

	logic clk;
	logic nrst;
	logic cs;
	logic wr;
	logic [1:0] adr;
	logic [7:0] wdata;
	logic pcm_valid;
	cdrom_pkg::pcm_pair_t pcm;
	logic [7:0] rdata;
	logic pcm_ready;
	cdrom_pkg::pcm_pair_t audio;
	logic audio_strobe;

	cdrom_pkg::pcm_pair_t exp_q[$];             // Accepted samples in stream order
	time acc_t[$];                              // Edge where each one was taken
	cdrom_pkg::vol_set_t vol_ref;               // Working set as last applied
	logic [2:0] idx_ref;                        // Bank index as last written

	cdrom_audio_top cdrom_audio_top_i (
		.i_clk          (clk),
		.i_nrst         (nrst),
		.i_cs           (cs),
		.i_write        (wr),
		.i_adr          (adr),
		.i_wdata        (wdata),
		.i_pcm_valid    (pcm_valid),
		.i_pcm          (pcm),
		.o_rdata        (rdata),
		.o_pcm_ready    (pcm_ready),
		.o_audio        (audio),
		.o_audio_strobe (audio_strobe)
	);

	initial begin
		clk = 1'b0;
		forever #(HALF) clk = ~clk;
	end

	// ----------------------------------------
	// Reporting and checks
	// ----------------------------------------
	task automatic report_mismatch(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got === exp) else report_mismatch(name, got, exp);
	endtask

	task automatic check_sample(input cdrom_pkg::pcm_pair_t exp);
		check_value("o_audio.l", audio.l, exp.l);
		check_value("o_audio.r", audio.r, exp.r);
	endtask

	// Product sum shifted right by 7 and clipped to signed 16 bits
	function automatic logic signed [15:0] mix_ref(input logic signed [15:0] a,
		input logic signed [15:0] b, input logic [7:0] va, input logic [7:0] vb);
		longint sum;
		sum = longint'(a) * longint'(va) + longint'(b) * longint'(vb);
		sum = sum >>> cdrom_pkg::VOL_UNITY_SHIFT;
		if (sum > 32767)
			return 16'sh7FFF;
		else if (sum < -32768)
			return 16'sh8000;
		return sum[15:0];
	endfunction

	function automatic cdrom_pkg::pcm_pair_t mix_pair(input cdrom_pkg::pcm_pair_t s,
		input cdrom_pkg::vol_set_t v);
		cdrom_pkg::pcm_pair_t m;
		m.l = mix_ref(s.l, s.r, v.ll, v.rl);
		m.r = mix_ref(s.l, s.r, v.lr, v.rr);
		return m;
	endfunction

	// Any data, ready and all empty sit above the index
	function automatic logic [7:0] status_byte(input logic any_data, input logic ready,
		input logic all_empty);
		return {2'b00, any_data, ready, all_empty, idx_ref};
	endfunction

	// ----------------------------------------
	// Bus and stream drivers entered on a falling edge
	// ----------------------------------------
	task automatic write_reg(input logic [1:0] a, input logic [7:0] d);
		cs = 1'b1;
		wr = 1'b1;
		adr = a;
		wdata = d;
		@(negedge clk);
		cs = 1'b0;
		wr = 1'b0;
		if (a == cdrom_pkg::REG_STATUS)
			idx_ref = d[2:0];               // Upper bits dropped by the DUT
	endtask

	task automatic expect_reg(input string name, input logic [1:0] a, input logic [7:0] exp);
		logic [7:0] d;
		cs = 1'b1;
		wr = 1'b0;
		adr = a;
		#(HALF / 2);                        // Read mux settled by mid low phase
		d = rdata;
		@(negedge clk);
		cs = 1'b0;
		check_value(name, d, exp);
	endtask

	task automatic stage_volumes(input cdrom_pkg::vol_set_t v);
		write_reg(cdrom_pkg::REG_STATUS, 8'h02);
		write_reg(cdrom_pkg::REG_DATA2, v.ll);
		write_reg(cdrom_pkg::REG_DATA3, v.lr);
		write_reg(cdrom_pkg::REG_STATUS, 8'h03);
		write_reg(cdrom_pkg::REG_DATA2, v.rl);
		write_reg(cdrom_pkg::REG_DATA1, v.rr);
	endtask

	task automatic apply_volumes(input cdrom_pkg::vol_set_t v);
		stage_volumes(v);
		write_reg(cdrom_pkg::REG_DATA3, 8'h20); // Bit 5 copies staging to working
		vol_ref = v;
	endtask

	// Host holds the sample until ready and it is taken at the next rising edge
	task automatic push_sample(input cdrom_pkg::pcm_pair_t s);
		pcm_valid = 1'b1;
		pcm = s;
		while (!pcm_ready)
			@(negedge clk);
		exp_q.push_back(s);
		acc_t.push_back($time + HALF);
		@(negedge clk);
		pcm_valid = 1'b0;
	endtask

	task automatic wait_strobes(input int n);
		repeat (n) begin
			@(negedge clk);
			while (!audio_strobe)
				@(negedge clk);
		end
	endtask

	// ----------------------------------------
	// Comparator
	// ----------------------------------------
	initial begin : compare
		cdrom_pkg::pcm_pair_t s;
		time last_t;                            // Previous strobe or reset release
		logic [15:0] gap;
		@(posedge nrst);
		last_t = $time;
		forever begin
			@(negedge clk);
			if (nrst && audio_strobe) begin
				gap = 16'(($time - last_t) / PERIOD); // Clocks since the last strobe
				last_t = $time;
				check_value("o_audio_strobe period", gap, 16'(cdrom_pkg::SAMPLE_PERIOD));
				// Only samples taken before the tick edge were in the FIFOs
				if (exp_q.size() > 0 && acc_t[0] < $time - HALF) begin
					s = exp_q.pop_front();
					void'(acc_t.pop_front());
				end else begin
					s = '0;                 // Underrun plays silence
				end
				check_sample(mix_pair(s, vol_ref));
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG);
		report_failure($sformatf("Run timed out after %0d sample periods", N_STROBES + 4));
	end

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------
	initial begin : stimulus
		cdrom_pkg::pcm_pair_t unity_in [4];
		cdrom_pkg::pcm_pair_t s;
		cdrom_pkg::vol_set_t v;
		void'($urandom(32'hb27d4a9c));
		nrst = 1'b0;
		cs = 1'b0;
		wr = 1'b0;
		adr = 2'd0;
		wdata = 8'h00;
		pcm_valid = 1'b0;
		pcm = '0;
		vol_ref = '0;
		idx_ref = 3'd0;
		repeat (2) @(negedge clk);
		nrst = 1'b1;

		// Zero volumes after reset give silence
		expect_reg("o_rdata status", cdrom_pkg::REG_STATUS, status_byte(1'b0, 1'b1, 1'b1));
		wait_strobes(2);
		check_sample('0);

		// Register readback
		write_reg(cdrom_pkg::REG_STATUS, 8'h01);
		expect_reg("o_rdata status", cdrom_pkg::REG_STATUS, status_byte(1'b0, 1'b1, 1'b1));
		write_reg(cdrom_pkg::REG_DATA2, 8'hA5);   // Enable 5'h05 and spare 3'h5
		expect_reg("o_rdata data3 bank 1", cdrom_pkg::REG_DATA3, 8'h00);
		write_reg(cdrom_pkg::REG_STATUS, 8'h00);
		expect_reg("o_rdata data3 bank 0", cdrom_pkg::REG_DATA3, 8'hA5);
		write_reg(cdrom_pkg::REG_STATUS, 8'hFA);  // Index 2
		expect_reg("o_rdata status", cdrom_pkg::REG_STATUS, status_byte(1'b0, 1'b1, 1'b1));
		expect_reg("o_rdata data3 bank 2", cdrom_pkg::REG_DATA3, 8'hA5);
		expect_reg("o_rdata data1", cdrom_pkg::REG_DATA1, 8'h00);
		expect_reg("o_rdata data2", cdrom_pkg::REG_DATA2, 8'h00);

		// Staged only so the output stays silent
		v = '{ll: 8'h80, rl: 8'h00, lr: 8'h00, rr: 8'h80};
		stage_volumes(v);
		push_sample('{r: 16'sh1234, l: -16'sh0567});
		wait_strobes(1);
		check_sample('0);

		// Unity passthrough
		apply_volumes(v);
		for (int i = 0; i < 4; i++) begin
			unity_in[i] = cdrom_pkg::pcm_pair_t'($urandom);
			push_sample(unity_in[i]);
		end
		for (int i = 0; i < 4; i++) begin
			wait_strobes(1);
			check_sample(unity_in[i]);
		end

		// Random matrices with cross terms
		repeat (N_RAND) begin
			apply_volumes(cdrom_pkg::vol_set_t'($urandom));
			repeat (3) push_sample(cdrom_pkg::pcm_pair_t'($urandom));
			wait_strobes(3);
		end

		// Gain near 4x on full scale saturates
		apply_volumes('{ll: 8'hFF, rl: 8'hFF, lr: 8'hFF, rr: 8'hFF});
		push_sample('{r: 16'sh7FFF, l: 16'sh7FFF});
		push_sample('{r: 16'sh8000, l: 16'sh8000});
		wait_strobes(1);
		check_sample('{r: 16'sh7FFF, l: 16'sh7FFF});
		wait_strobes(1);
		check_sample('{r: 16'sh8000, l: 16'sh8000});

		// Back-pressure fills both FIFOs between two ticks
		for (int i = 0; i < cdrom_pkg::FIFO_DEPTH; i++) begin
			s = cdrom_pkg::pcm_pair_t'($urandom);
			push_sample(s);
		end
		check_value("o_pcm_ready", pcm_ready, 16'h0000);
		expect_reg("o_rdata status", cdrom_pkg::REG_STATUS, status_byte(1'b1, 1'b0, 1'b0));
		repeat (3) push_sample(cdrom_pkg::pcm_pair_t'($urandom)); // One credit per strobe
		wait_strobes(cdrom_pkg::FIFO_DEPTH);

		// Underrun
		wait_strobes(2);
		check_sample('0);
		expect_reg("o_rdata status", cdrom_pkg::REG_STATUS, status_byte(1'b0, 1'b1, 1'b1));

		$display("All tests passed");
		$finish;
	end

endmodule

/* cdrom_audio.f */
source/cdrom_pkg.sv
source/cdrom_pcm_fifo.sv
source/cdrom_pcm_feeder.sv
source/cdrom_host_regs.sv
source/cdrom_audio_mixer.sv
source/cdrom_audio_top.sv
tests/cdrom_audio_tb.sv
